// File: Makefile
# Verilator flow for the execute stage
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= exec_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the run prints the pass line
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
+incdir+src
src/exec_pkg.sv
src/exec_if.sv
src/op_decode.sv
src/alu_unit.sv
src/mul_unit.sv
src/result_arbiter.sv
src/exec_top.sv
verif/exec_asserts.sv
verif/exec_tb.sv

// File: src/alu_unit.sv
// ----------------------------
// Single-cycle ALU with one output register
// Result holds under back-pressure, refills on the drain cycle
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module alu_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    unit_issue_if.dst         iss_i,
    input  exec_pkg::alu_fn_e fn_i,
    unit_result_if.src        res_o
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic [`EXEC_XLEN-1:0]  result;
    logic [SHAMT_W-1:0]     shamt;
    logic                   accept;
    logic                   valid_q;
    logic [`EXEC_XLEN-1:0]  data_q;
    logic [`EXEC_TAG_W-1:0] tag_q;

    // Shift amount from the low bits of operand b
    assign shamt = iss_i.b[SHAMT_W-1:0];

    // Combinational result
    always_comb begin
        case (fn_i)
            ALU_ADD: result = iss_i.a + iss_i.b;
            ALU_SUB: result = iss_i.a - iss_i.b;
            ALU_AND: result = iss_i.a & iss_i.b;
            ALU_OR:  result = iss_i.a | iss_i.b;
            ALU_XOR: result = iss_i.a ^ iss_i.b;
            ALU_SLL: result = iss_i.a << shamt;
            ALU_SRL: result = iss_i.a >> shamt;
            default: result = '0;
        endcase
    end

    // Room when empty or draining this cycle
    assign iss_i.ready = !valid_q || res_o.ready;
    assign accept      = iss_i.valid && iss_i.ready;

    // Valid flag, set on accept, cleared on drain
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (res_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= result;
            tag_q  <= iss_i.tag;
        end
    end

    assign res_o.valid = valid_q;
    assign res_o.data  = data_q;
    assign res_o.tag   = tag_q;

endmodule

// File: src/exec_consts.svh
// ----------------------------
// Width and step-count macros for the execute stage
// Include in any file that sizes operands, tags or multiplier steps
// ----------------------------

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and result width
`define EXEC_XLEN 32

// Tag width, enough for 16 operations in flight
`define EXEC_TAG_W 4

// Multiplier iterations, two multiplier bits retired per step
`define EXEC_MUL_STEPS 16

`endif

// File: src/exec_if.sv
// ----------------------------
// Issue and result links between decode, units and arbiter
// Both use valid/ready; src drives payload, dst returns ready
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

// Operation from decode to one execution unit
interface unit_issue_if;
    import exec_pkg::*;

    logic                   valid;
    logic                   ready;
    op_e                    op;
    logic [`EXEC_XLEN-1:0]  a;
    logic [`EXEC_XLEN-1:0]  b;
    logic [`EXEC_TAG_W-1:0] tag;

    // Decode side
    modport src (
        output valid,
        output op,
        output a,
        output b,
        output tag,
        input  ready
    );

    // Unit side
    modport dst (
        input  valid,
        input  op,
        input  a,
        input  b,
        input  tag,
        output ready
    );
endinterface

// Result from one execution unit to the writeback arbiter
interface unit_result_if;
    logic                   valid;
    logic                   ready;
    logic [`EXEC_XLEN-1:0]  data;
    logic [`EXEC_TAG_W-1:0] tag;

    // Unit side
    modport src (
        output valid,
        output data,
        output tag,
        input  ready
    );

    // Arbiter side
    modport dst (
        input  valid,
        input  data,
        input  tag,
        output ready
    );
endinterface

// File: src/exec_pkg.sv
// ----------------------------
// Shared types of the execute stage
// Opcodes, ALU functions and multiplier FSM states
// ----------------------------

package exec_pkg;

    // Issued opcode, 3 bits wide
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } op_e;

    // ALU function, one per non-multiply opcode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_fn_e;

    // Iterative multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

endpackage

// File: src/exec_top.sv
// ----------------------------
// Execute stage top: decode, ALU, multiplier, writeback arbiter
// Plain valid/ready ports on the issue and writeback sides
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Issue side
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  exec_pkg::op_e          issue_op_i,
    input  logic [`EXEC_XLEN-1:0]  issue_a_i,
    input  logic [`EXEC_XLEN-1:0]  issue_b_i,
    input  logic [`EXEC_TAG_W-1:0] issue_tag_i,
    // Writeback side
    output logic                   result_valid_o,
    input  logic                   result_ready_i,
    output logic [`EXEC_XLEN-1:0]  result_data_o,
    output logic [`EXEC_TAG_W-1:0] result_tag_o
);
    import exec_pkg::*;

    alu_fn_e alu_fn;

    // Unit links
    unit_issue_if  alu_iss ();
    unit_issue_if  mul_iss ();
    unit_result_if alu_res ();
    unit_result_if mul_res ();

    op_decode u_decode (
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_a_i     (issue_a_i),
        .issue_b_i     (issue_b_i),
        .issue_tag_i   (issue_tag_i),
        .issue_ready_o (issue_ready_o),
        .alu_o         (alu_iss),
        .mul_o         (mul_iss),
        .alu_fn_o      (alu_fn)
    );

    alu_unit u_alu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .iss_i   (alu_iss),
        .fn_i    (alu_fn),
        .res_o   (alu_res)
    );

    mul_unit u_mul (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .iss_i   (mul_iss),
        .res_o   (mul_res)
    );

    // Single writeback port shared by both units
    result_arbiter u_arb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .alu_i          (alu_res),
        .mul_i          (mul_res),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_tag_o   (result_tag_o)
    );

endmodule

// File: src/mul_unit.sv
// ----------------------------
// Radix-4 iterative multiplier, low half of the product
// One operation at a time; result held in MUL_DONE until drained
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module mul_unit (
    input  logic       clk_i,
    input  logic       rst_n_i,
    unit_issue_if.dst  iss_i,
    unit_result_if.src res_o
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(`EXEC_MUL_STEPS);

    mul_state_e             state_q;
    mul_state_e             state_d;
    logic [CNT_W-1:0]       cnt_q;
    logic                   start;
    logic                   last_step;
    logic [`EXEC_XLEN-1:0]  mcand_q;
    logic [`EXEC_XLEN-1:0]  mplr_q;
    logic [`EXEC_XLEN-1:0]  acc_q;
    logic [`EXEC_TAG_W-1:0] tag_q;
    logic [`EXEC_XLEN-1:0]  pp;

    // Accept in idle, or in done while the result leaves
    assign iss_i.ready = (state_q == MUL_IDLE) || (state_q == MUL_DONE && res_o.ready);
    assign start       = iss_i.valid && iss_i.ready;
    assign last_step   = (cnt_q == CNT_W'(`EXEC_MUL_STEPS - 1));

    // Partial product for two multiplier bits
    always_comb begin
        case (mplr_q[1:0])
            2'd0: pp = '0;
            2'd1: pp = mcand_q;
            2'd2: pp = mcand_q << 1;
            2'd3: pp = mcand_q + (mcand_q << 1);
            default: pp = '0;
        endcase
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            MUL_IDLE: begin
                if (start) state_d = MUL_BUSY;
            end
            MUL_BUSY: begin
                if (last_step) state_d = MUL_DONE;
            end
            MUL_DONE: begin
                // Back to back: drain and restart together
                if (start) begin
                    state_d = MUL_BUSY;
                end else if (res_o.ready) begin
                    state_d = MUL_IDLE;
                end
            end
            default: state_d = MUL_IDLE;
        endcase
    end

    // FSM and step counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                cnt_q <= '0;
            end else if (state_q == MUL_BUSY) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Datapath, multiplicand moves left while multiplier bits drain right
    always_ff @(posedge clk_i) begin
        if (start) begin
            mcand_q <= iss_i.a;
            mplr_q  <= iss_i.b;
            acc_q   <= '0;
            tag_q   <= iss_i.tag;
        end else if (state_q == MUL_BUSY) begin
            acc_q   <= acc_q + pp;
            mcand_q <= mcand_q << 2;
            mplr_q  <= mplr_q >> 2;
        end
    end

    assign res_o.valid = (state_q == MUL_DONE);
    assign res_o.data  = acc_q;
    assign res_o.tag   = tag_q;

endmodule

// File: src/op_decode.sv
// ----------------------------
// Steers an issued operation to the ALU or the multiplier
// Only the selected link sees valid; its ready comes back
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module op_decode (
    input  logic                   issue_valid_i,
    input  exec_pkg::op_e          issue_op_i,
    input  logic [`EXEC_XLEN-1:0]  issue_a_i,
    input  logic [`EXEC_XLEN-1:0]  issue_b_i,
    input  logic [`EXEC_TAG_W-1:0] issue_tag_i,
    output logic                   issue_ready_o,
    unit_issue_if.src              alu_o,
    unit_issue_if.src              mul_o,
    output exec_pkg::alu_fn_e      alu_fn_o
);
    import exec_pkg::*;

    // High when the opcode targets the multiplier
    logic to_mul;

    // Opcode classification
    always_comb begin
        to_mul   = 1'b0;
        alu_fn_o = ALU_ADD;
        case (issue_op_i)
            OP_ADD: alu_fn_o = ALU_ADD;
            OP_SUB: alu_fn_o = ALU_SUB;
            OP_AND: alu_fn_o = ALU_AND;
            OP_OR:  alu_fn_o = ALU_OR;
            OP_XOR: alu_fn_o = ALU_XOR;
            OP_SLL: alu_fn_o = ALU_SLL;
            OP_SRL: alu_fn_o = ALU_SRL;
            OP_MUL: to_mul   = 1'b1;
            default: alu_fn_o = ALU_ADD;
        endcase
    end

    // Payload broadcast to both units, valid gated per target
    assign alu_o.valid = issue_valid_i && !to_mul;
    assign alu_o.op    = issue_op_i;
    assign alu_o.a     = issue_a_i;
    assign alu_o.b     = issue_b_i;
    assign alu_o.tag   = issue_tag_i;

    assign mul_o.valid = issue_valid_i && to_mul;
    assign mul_o.op    = issue_op_i;
    assign mul_o.a     = issue_a_i;
    assign mul_o.b     = issue_b_i;
    assign mul_o.tag   = issue_tag_i;

    // Ready of the targeted unit only
    assign issue_ready_o = to_mul ? mul_o.ready : alu_o.ready;

endmodule

// File: src/result_arbiter.sv
// ----------------------------
// Fair two-way writeback arbiter with data and tag mux
// Conflicts alternate; a stalled grant stays put until taken
// ----------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module result_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    unit_result_if.dst             alu_i,
    unit_result_if.dst             mul_i,
    input  logic                   result_ready_i,
    output logic                   result_valid_o,
    output logic [`EXEC_XLEN-1:0]  result_data_o,
    output logic [`EXEC_TAG_W-1:0] result_tag_o
);
    // Set when the ALU won the last granted conflict
    logic last_alu_q;
    // Grant of a stalled result, kept for the next cycle
    logic hold_q;
    logic hold_mul_q;
    logic conflict;
    logic grant_alu;
    logic grant_mul;

    assign conflict = alu_i.valid && mul_i.valid;

    // Lone source wins, conflict goes to the one not served last
    // Clear flag after reset, so the ALU takes the first conflict
    always_comb begin
        if (hold_q) begin
            grant_mul = hold_mul_q;
        end else if (conflict) begin
            grant_mul = last_alu_q;
        end else begin
            grant_mul = mul_i.valid;
        end
        grant_alu = alu_i.valid && !grant_mul;
    end

    // Ready only to the winner
    assign alu_i.ready = grant_alu && result_ready_i;
    assign mul_i.ready = grant_mul && result_ready_i;

    assign result_valid_o = alu_i.valid || mul_i.valid;
    assign result_data_o  = grant_mul ? mul_i.data : alu_i.data;
    assign result_tag_o   = grant_mul ? mul_i.tag  : alu_i.tag;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_alu_q <= 1'b0;
            hold_q     <= 1'b0;
            hold_mul_q <= 1'b0;
        end else begin
            // Only a granted conflict moves the fairness flag
            if (conflict && result_ready_i) begin
                last_alu_q <= grant_alu;
            end
            // Freeze the mux while writeback is stalled
            hold_q     <= result_valid_o && !result_ready_i;
            hold_mul_q <= grant_mul;
        end
    end

endmodule

// File: verif/exec_asserts.sv
// ------------------------------
// Concurrent checks on the writeback arbiter
// Bound into the execute stage top level
// ------------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_asserts (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   alu_valid_i,
    input logic                   mul_valid_i,
    input logic                   grant_alu_i,
    input logic                   grant_mul_i,
    input exec_pkg::mul_state_e   mul_state_i,
    input logic                   result_valid_i,
    input logic                   result_ready_i,
    input logic [`EXEC_XLEN-1:0]  result_data_i,
    input logic [`EXEC_TAG_W-1:0] result_tag_i
);
    import exec_pkg::*;

    // Failure counts, one per property
    int onehot_fails = 0;
    int fair_fails   = 0;
    int hold_fails   = 0;
    int mul_fails    = 0;
    int fail_cnt;

    logic conflict;
    logic stalled_q;
    logic last_mul_q;

    assign fail_cnt = onehot_fails + fair_fails + hold_fails + mul_fails;
    assign conflict = alu_valid_i && mul_valid_i;

    // Own copy of the last conflict winner and of the stall state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stalled_q  <= 1'b0;
            // As if the multiplier won, so the ALU takes the first conflict
            last_mul_q <= 1'b1;
        end else begin
            stalled_q <= result_valid_i && !result_ready_i;
            if (conflict && result_ready_i) begin
                last_mul_q <= grant_mul_i;
            end
        end
    end

    // At most one grant, only to a valid source, one whenever output is valid
    grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(grant_alu_i && grant_mul_i) && (result_valid_i == (grant_alu_i || grant_mul_i))
        && (!grant_alu_i || alu_valid_i) && (!grant_mul_i || mul_valid_i))
        else begin $error("writeback grant is not one-hot"); onehot_fails++; end

    // A fresh conflict goes to the source that lost the previous one
    conflict_alternates: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (conflict && result_ready_i && !stalled_q) |-> (grant_mul_i != last_mul_q))
        else begin $error("conflict grant did not alternate"); fair_fails++; end

    // Stalled result stays put
    stall_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_i && !result_ready_i) |=>
        (result_valid_i && $stable(result_data_i) && $stable(result_tag_i)))
        else begin $error("stalled writeback changed"); hold_fails++; end

    // Multiplier keeps its result while writeback is stalled
    mul_done_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mul_state_i == MUL_DONE && !result_ready_i) |=> (mul_state_i == MUL_DONE))
        else begin $error("multiplier left MUL_DONE under stall"); mul_fails++; end

endmodule

bind exec_top exec_asserts u_sva (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alu_valid_i    (alu_res.valid),
    .mul_valid_i    (mul_res.valid),
    .grant_alu_i    (u_arb.grant_alu),
    .grant_mul_i    (u_arb.grant_mul),
    .mul_state_i    (u_mul.state_q),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_data_i  (result_data_o),
    .result_tag_i   (result_tag_o)
);

// File: verif/exec_tb.sv
// ------------------------------
// Testbench for the execute stage, top module exec_tb
// Applies an operation table and checks results by tag
// ------------------------------

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   issue_valid_i;
    logic                   issue_ready_o;
    op_e                    issue_op_i;
    logic [`EXEC_XLEN-1:0]  issue_a_i;
    logic [`EXEC_XLEN-1:0]  issue_b_i;
    logic [`EXEC_TAG_W-1:0] issue_tag_i;
    logic                   result_valid_o;
    logic                   result_ready_i;
    logic [`EXEC_XLEN-1:0]  result_data_o;
    logic [`EXEC_TAG_W-1:0] result_tag_o;

    // Operation table, expected values worked out by hand
    op_e                   tbl_op[$];
    logic [`EXEC_XLEN-1:0] tbl_a[$];
    logic [`EXEC_XLEN-1:0] tbl_b[$];
    logic [`EXEC_XLEN-1:0] tbl_exp[$];

    // Scoreboard indexed by tag, plus per-unit issue order
    logic pend [0:15];
    int   pend_idx [0:15];
    int   alu_order[$];
    int   mul_order[$];
    int   done_cnt;
    int   alu_pass;
    integer seed = 32'hb976;

    int err_value;
    int err_proto;
    int err_timeout;
    int err_assert;

    exec_top UUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ready_o  (issue_ready_o),
        .issue_op_i     (issue_op_i),
        .issue_a_i      (issue_a_i),
        .issue_b_i      (issue_b_i),
        .issue_tag_i    (issue_tag_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_data_o  (result_data_o),
        .result_tag_o   (result_tag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic void add_row(op_e op, logic [31:0] a, logic [31:0] b, logic [31:0] exp);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_exp.push_back(exp);
    endfunction

    function automatic void build_table();
        // ALU opcodes, shifts by 31 and by amounts above 31
        add_row(OP_ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000C);
        add_row(OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
        add_row(OP_SUB, 32'h0000_0010, 32'h0000_0020, 32'hFFFF_FFF0);
        add_row(OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200);
        add_row(OP_OR,  32'hF000_000F, 32'h0F00_00F0, 32'hFF00_00FF);
        add_row(OP_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555);
        add_row(OP_SLL, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000);
        add_row(OP_SLL, 32'h0000_0003, 32'h0000_0021, 32'h0000_0006);
        add_row(OP_SRL, 32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
        add_row(OP_SRL, 32'hF000_0000, 32'h0000_0024, 32'h0F00_0000);
        // Multiplies, zero, all-ones and negative operands
        add_row(OP_MUL, 32'h0000_0003, 32'h0000_0007, 32'h0000_0015);
        add_row(OP_MUL, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
        add_row(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(OP_MUL, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFA);
        add_row(OP_MUL, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
        add_row(OP_MUL, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
        // One multiply followed by a long ALU stream
        add_row(OP_MUL, 32'hFFFF_FFF9, 32'hFFFF_FFFD, 32'h0000_0015);
        add_row(OP_ADD, 32'h0000_0100, 32'h0000_0001, 32'h0000_0101);
        add_row(OP_SUB, 32'h0000_0100, 32'h0000_0001, 32'h0000_00FF);
        add_row(OP_AND, 32'hFFFF_0000, 32'h1234_5678, 32'h1234_0000);
        add_row(OP_OR,  32'h0000_FFFF, 32'h1234_0000, 32'h1234_FFFF);
        add_row(OP_XOR, 32'hFFFF_FFFF, 32'h1234_5678, 32'hEDCB_A987);
        add_row(OP_SLL, 32'h0000_00FF, 32'h0000_0008, 32'h0000_FF00);
        add_row(OP_SRL, 32'h0000_FF00, 32'h0000_0008, 32'h0000_00FF);
        add_row(OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000);
        add_row(OP_SUB, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
        add_row(OP_SLL, 32'hFFFF_FFFF, 32'h0000_003F, 32'h8000_0000);
        add_row(OP_SRL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(OP_AND, 32'h0000_00F0, 32'h0000_003C, 32'h0000_0030);
        add_row(OP_OR,  32'h8000_0000, 32'h0000_0001, 32'h8000_0001);
        add_row(OP_XOR, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000);
        add_row(OP_ADD, 32'h1111_1111, 32'h2222_2222, 32'h3333_3333);
        add_row(OP_SUB, 32'h3333_3333, 32'h1111_1111, 32'h2222_2222);
    endfunction

    // Retire one delivered result against the scoreboard
    task automatic check_result(input logic [3:0] tag, input logic [31:0] data);
        int idx;
        if (!pend[tag]) begin
            $display("Result with tag %0d arrived while no operation with that tag was in flight",
                     tag);
            err_proto++;
            return;
        end
        idx       = pend_idx[tag];
        pend[tag] = 1'b0;
        done_cnt++;
        if (tbl_op[idx] == OP_MUL) begin
            if (mul_order.size() == 0 || mul_order[0] != idx) begin
                $display("Multiplier result for entry %0d came back out of issue order", idx);
                err_proto++;
            end
            if (mul_order.size() != 0) void'(mul_order.pop_front());
            alu_pass = 0;
        end else begin
            if (alu_order.size() == 0 || alu_order[0] != idx) begin
                $display("ALU result for entry %0d came back out of issue order", idx);
                err_proto++;
            end
            if (alu_order.size() != 0) void'(alu_order.pop_front());
            // ALU won while a multiply result was waiting
            if (UUT.u_mul.state_q == MUL_DONE) begin
                alu_pass++;
                if (alu_pass > 1) begin
                    $display("A waiting multiply result was passed by %0d ALU results", alu_pass);
                    err_proto++;
                end
            end
        end
        if (data !== tbl_exp[idx]) begin
            $display("ERROR t=%0t result_data_o (tag %0d): got %h, expected %h",
                     $time, tag, data, tbl_exp[idx]);
            err_value++;
        end
    endtask

    // Random writeback back-pressure, about one stall in four
    initial begin
        result_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            result_ready_i <= rst_n_i && (($random(seed) & 3) != 0);
        end
    end

    // Writeback monitor, sampled on the falling edge
    initial begin : monitor
        logic                   stall_q;
        logic [`EXEC_XLEN-1:0]  held_data;
        logic [`EXEC_TAG_W-1:0] held_tag;
        stall_q = 1'b0;
        forever begin
            @(negedge clk_i);
            if (stall_q) begin
                if (!result_valid_o) begin
                    $display("Stalled result disappeared before it was taken at t=%0t", $time);
                    err_proto++;
                end
                if (result_data_o !== held_data) begin
                    $display("ERROR t=%0t result_data_o: got %h, expected %h",
                             $time, result_data_o, held_data);
                    err_value++;
                end
                if (result_tag_o !== held_tag) begin
                    $display("ERROR t=%0t result_tag_o: got %h, expected %h",
                             $time, result_tag_o, held_tag);
                    err_value++;
                end
            end
            stall_q   = result_valid_o && !result_ready_i;
            held_data = result_data_o;
            held_tag  = result_tag_o;
            if (result_valid_o && result_ready_i) begin
                check_result(result_tag_o, result_data_o);
            end
        end
    end

    initial begin : main
        int                     i;
        int                     waited;
        logic [`EXEC_TAG_W-1:0] tag;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = OP_ADD;
        issue_a_i     = '0;
        issue_b_i     = '0;
        issue_tag_i   = '0;
        for (i = 0; i < 16; i++) pend[i] = 1'b0;
        build_table();
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Idle output before the first issue
        repeat (3) begin
            @(negedge clk_i);
            if (result_valid_o !== 1'b0) begin
                $display("ERROR t=%0t result_valid_o: got %b, expected 0", $time, result_valid_o);
                err_value++;
            end
        end
        @(posedge clk_i);
        for (i = 0; i < tbl_op.size() && err_timeout == 0; i++) begin
            tag    = i[`EXEC_TAG_W-1:0];
            waited = 0;
            // Tag reuse waits for the older operation to retire
            while (pend[tag] && waited < ISSUE_TIMEOUT) begin
                issue_valid_i <= 1'b0;
                @(posedge clk_i);
                waited++;
            end
            if (pend[tag]) begin
                $display("Timed out waiting for tag %0d to return before reuse", tag);
                err_timeout++;
            end else begin
                issue_valid_i <= 1'b1;
                issue_op_i    <= tbl_op[i];
                issue_a_i     <= tbl_a[i];
                issue_b_i     <= tbl_b[i];
                issue_tag_i   <= tag;
                waited = 0;
                @(negedge clk_i);
                while (!issue_ready_o && waited < ISSUE_TIMEOUT) begin
                    @(negedge clk_i);
                    waited++;
                end
                if (!issue_ready_o) begin
                    $display("Timed out waiting for issue_ready_o on entry %0d", i);
                    err_timeout++;
                end else begin
                    // Transfer edge
                    @(posedge clk_i);
                    pend_idx[tag] = i;
                    pend[tag]     = 1'b1;
                    if (tbl_op[i] == OP_MUL) mul_order.push_back(i);
                    else alu_order.push_back(i);
                end
            end
        end
        issue_valid_i <= 1'b0;
        waited = 0;
        while (done_cnt < tbl_op.size() && waited < DRAIN_TIMEOUT && err_timeout == 0) begin
            @(negedge clk_i);
            waited++;
        end
        if (err_timeout == 0 && done_cnt < tbl_op.size()) begin
            $display("Timed out with %0d of %0d results returned", done_cnt, tbl_op.size());
            err_timeout++;
        end
        // Quiet tail so a duplicate result would still be seen
        repeat (20) @(negedge clk_i);
        err_assert = UUT.u_sva.fail_cnt;
        $display("Results %0d/%0d, errors: value %0d, protocol %0d, assertion %0d, timeout %0d",
                 done_cnt, tbl_op.size(), err_value, err_proto, err_assert, err_timeout);
        if (err_value + err_proto + err_assert + err_timeout == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
